/* Makefile */
# Verilator flow for the UMI device endpoint
# make lint  : lint the design and the testbench
# make sim   : build and run, exit status gives pass or fail
# make clean : remove build output

TOP = tb_umi_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* all.f */
+incdir+testbench
hw/umi_pkg.sv
hw/umi_decode.sv
hw/umi_endpoint.sv
hw/umi_mem.sv
hw/umi_top.sv
testbench/tb_umi_top.sv

/* hw/umi_decode.sv */
//####################
// Command decoder for the UMI endpoint. Purely combinational:
// flags the request kind and builds the response command word
//####################

`timescale 1ns/1ns

module umi_decode
(
   input  umi_pkg::umi_cmd_t cmd,
   output logic              is_read,
   output logic              is_write,
   output logic              is_posted,
   output umi_pkg::umi_cmd_t resp_cmd
);

   // Request classification
   // Invalid codes, response codes included, raise no flag
   always_comb
   begin
      is_read   = (cmd.opcode == umi_pkg::UMI_REQ_READ);
      is_write  = (cmd.opcode == umi_pkg::UMI_REQ_WRITE);
      is_posted = (cmd.opcode == umi_pkg::UMI_REQ_WRPOSTED);
   end

   //####################
   // Response command
   //####################
   always_comb
   begin
      resp_cmd = cmd;                                 // Echo user, len, size
      if (is_read)
      begin
         resp_cmd.opcode = umi_pkg::UMI_RESP_READ;
      end
      else
      begin
         // Posted and invalid never get here in a real response,
         // the endpoint does not send one for them
         resp_cmd.opcode = umi_pkg::UMI_RESP_WRITE;
      end
   end

endmodule

/* hw/umi_endpoint.sv */
//####################
// UMI device endpoint. Takes request packets, drives the local
// memory port and returns read and write-ack responses, holding
// them under back-pressure. REG=1 adds an output register stage
//####################

`timescale 1ns/1ns

module umi_endpoint
#(
   parameter int REG = 0                           // 1 = register response port
)
(
   input  logic                 clk,
   input  logic                 nreset,
   // Request port
   input  umi_pkg::umi_packet_t req,
   input  logic                 req_valid,
   output logic                 req_ready,
   // Response port
   output umi_pkg::umi_packet_t resp,
   output logic                 resp_valid,
   input  logic                 resp_ready,
   // Local memory port
   output umi_pkg::loc_req_t    loc_req,
   input  umi_pkg::umi_data_t   loc_rddata,
   input  logic                 loc_ready
);

   logic                 dec_read;
   logic                 dec_write;
   logic                 dec_posted;
   umi_pkg::umi_cmd_t    dec_resp_cmd;
   logic                 stall;
   logic                 resp_start;
   logic                 loc_resp_vld;             // Memory data due this cycle
   logic                 vld_keep;
   logic                 inner_vld;
   umi_pkg::umi_cmd_t    hdr_cmd;
   umi_pkg::umi_addr_t   hdr_dst;
   umi_pkg::umi_addr_t   hdr_src;
   umi_pkg::umi_data_t   data_keep;
   umi_pkg::umi_data_t   inner_data;
   umi_pkg::umi_packet_t inner_pkt;
   logic                 vld_pipe;
   umi_pkg::umi_packet_t pkt_pipe;

   umi_decode u_decode
   (
      .cmd       (req.cmd),
      .is_read   (dec_read),
      .is_write  (dec_write),
      .is_posted (dec_posted),
      .resp_cmd  (dec_resp_cmd)
   );

   //####################
   // Request side
   //####################
   // Stall while a response sits in the output and the host is not taking it
   assign stall = (REG != 0) ? ((vld_pipe | inner_vld) & ~resp_ready)
                             : (inner_vld & ~resp_ready);

   assign req_ready = loc_ready & ~stall;

   // Memory strobes are held off during a stall so that
   // read/write with ready is exactly an accepted request
   assign loc_req.addr   = req.dstaddr;
   assign loc_req.wrdata = req.data;
   assign loc_req.read   = dec_read & req_valid & ~stall;
   assign loc_req.write  = (dec_write | dec_posted) & req_valid & ~stall;

   assign resp_start = (dec_read | dec_write) & req_valid & req_ready;

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         loc_resp_vld <= 1'b0;
      end
      else
      begin
         loc_resp_vld <= resp_start;
      end
   end

   // Response header, addresses swapped
   always_ff @(posedge clk)
   begin
      if (resp_start)
      begin
         hdr_cmd <= dec_resp_cmd;
         hdr_dst <= req.srcaddr;
         hdr_src <= req.dstaddr;
      end
   end

   //####################
   // Back-pressure hold
   //####################
   // Read data only lives one cycle at the memory output
   always_ff @(posedge clk)
   begin
      if (loc_resp_vld)
      begin
         data_keep <= loc_rddata;
      end
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         vld_keep <= 1'b0;
      end
      else if (loc_resp_vld & ~resp_ready)
      begin
         vld_keep <= 1'b1;                         // Host not ready, hold on
      end
      else if (resp_ready)
      begin
         vld_keep <= 1'b0;
      end
   end

   assign inner_vld  = loc_resp_vld | vld_keep;
   assign inner_data = loc_resp_vld ? loc_rddata : data_keep;
   assign inner_pkt  = '{cmd: hdr_cmd, dstaddr: hdr_dst, srcaddr: hdr_src, data: inner_data};

   //####################
   // Optional output stage
   //####################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         vld_pipe <= 1'b0;
      end
      else if (resp_ready)
      begin
         vld_pipe <= inner_vld;
      end
   end

   always_ff @(posedge clk)
   begin
      if (resp_ready)
      begin
         pkt_pipe <= inner_pkt;
      end
   end

   assign resp_valid = (REG != 0) ? vld_pipe : inner_vld;
   assign resp       = (REG != 0) ? pkt_pipe : inner_pkt;

   // A stalled response keeps both valid and contents
   a_resp_hold: assert property (@(posedge clk) disable iff (!nreset)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp));

   // Write recovery in the memory blocks the request port for a cycle
   a_no_accept_recovery: assert property (@(posedge clk) disable iff (!nreset)
      req_valid && req_ready && loc_req.write |=> !req_ready);

endmodule

/* hw/umi_mem.sv */
//####################
// Word-addressed local memory behind the UMI endpoint.
// Reads return one cycle after the accepted edge; every write
// drops ready for one cycle to model write recovery
//####################

`timescale 1ns/1ns

module umi_mem
#(
   parameter int MEM_WORDS = umi_pkg::MEM_WORDS_DEFAULT   // Power of two, >= 4
)
(
   input  logic               clk,
   input  logic               nreset,
   input  umi_pkg::loc_req_t  loc_req,
   output umi_pkg::umi_data_t rddata,
   output logic               ready
);

   localparam int IDX_W = $clog2(MEM_WORDS);

   umi_pkg::umi_data_t mem_q [MEM_WORDS];
   logic [IDX_W-1:0]   idx;
   logic               busy;
   logic               rd_acc;
   logic               wr_acc;

   // Word index, byte offset dropped, wraps at MEM_WORDS
   assign idx = loc_req.addr[IDX_W+1:2];

   assign ready  = ~busy;
   assign rd_acc = loc_req.read & ready;
   assign wr_acc = loc_req.write & ready;

   //####################
   // Storage
   //####################
   always_ff @(posedge clk)
   begin
      if (wr_acc)
      begin
         mem_q[idx] <= loc_req.wrdata;
      end
      if (rd_acc)
      begin
         rddata <= mem_q[idx];                     // Held until next read
      end
   end

   // Write recovery
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         busy <= 1'b0;
      end
      else
      begin
         busy <= wr_acc;
      end
   end

   // The endpoint decodes one opcode at a time
   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!nreset)
      !(loc_req.read && loc_req.write));

endmodule

/* hw/umi_pkg.sv */
//####################
// Shared types for the UMI device endpoint: widths, opcodes,
// command and packet layouts, and the local memory port.
// Every RTL file and the testbench reach these by umi_pkg::name
//####################

package umi_pkg;

   //####################
   // Widths
   //####################
   localparam int UMI_AW = 32;       // Byte address
   localparam int UMI_DW = 32;       // One data word per packet
   localparam int UMI_OPW = 5;       // Opcode field

   // Default local memory depth, in words
   localparam int MEM_WORDS_DEFAULT = 64;

   typedef logic [UMI_AW-1:0] umi_addr_t;
   typedef logic [UMI_DW-1:0] umi_data_t;

   //####################
   // Opcodes
   //####################
   // Requests are odd, responses even. Only the three requests
   // below are served, anything else is swallowed by the endpoint
   typedef enum logic [UMI_OPW-1:0] {
      UMI_REQ_READ     = 5'd1,
      UMI_RESP_READ    = 5'd2,
      UMI_REQ_WRPOSTED = 5'd3,       // Write without acknowledge
      UMI_RESP_WRITE   = 5'd4,
      UMI_REQ_WRITE    = 5'd5        // Write with acknowledge
   } umi_opcode_e;

   //####################
   // Command word
   //####################
   // Opcode sits in the low bits; user, len and size are only
   // carried through to the response
   typedef struct packed {
      logic [15:0]        user;
      logic [7:0]         len;
      logic [2:0]         size;
      logic [UMI_OPW-1:0] opcode;
   } umi_cmd_t;

   // Full packet, same layout on the request and response ports
   typedef struct packed {
      umi_cmd_t  cmd;
      umi_addr_t dstaddr;
      umi_addr_t srcaddr;
      umi_data_t data;
   } umi_packet_t;

   //####################
   // Local memory port
   //####################
   // Driven by the endpoint; read and write already carry the
   // request valid and the stall hold-off
   typedef struct packed {
      umi_addr_t addr;
      logic      read;
      logic      write;
      umi_data_t wrdata;
   } loc_req_t;

endpackage

/* hw/umi_top.sv */
//####################
// Top level of the UMI device: endpoint plus local memory.
// REG and MEM_WORDS are set here and handed down
//####################

`timescale 1ns/1ns

module umi_top
#(
   parameter int REG       = 0,
   parameter int MEM_WORDS = umi_pkg::MEM_WORDS_DEFAULT
)
(
   input  logic                 clk,
   input  logic                 nreset,
   input  umi_pkg::umi_packet_t req,
   input  logic                 req_valid,
   output logic                 req_ready,
   output umi_pkg::umi_packet_t resp,
   output logic                 resp_valid,
   input  logic                 resp_ready
);

   umi_pkg::loc_req_t  loc_req;
   umi_pkg::umi_data_t loc_rddata;
   logic               loc_ready;

   umi_endpoint #(.REG(REG)) u_endpoint
   (
      .clk        (clk),
      .nreset     (nreset),
      .req        (req),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .resp       (resp),
      .resp_valid (resp_valid),
      .resp_ready (resp_ready),
      .loc_req    (loc_req),
      .loc_rddata (loc_rddata),
      .loc_ready  (loc_ready)
   );

   umi_mem #(.MEM_WORDS(MEM_WORDS)) u_mem
   (
      .clk     (clk),
      .nreset  (nreset),
      .loc_req (loc_req),
      .rddata  (loc_rddata),
      .ready   (loc_ready)
   );

endmodule

/* testbench/tb_umi_checks.svh */
//####################
// Compare and wait tasks for the UMI endpoint testbench.
// Included inside the testbench module after its signals
//####################

`ifndef TB_UMI_CHECKS_SVH
`define TB_UMI_CHECKS_SVH

// Stop the run at the first problem
task automatic fail_now(input string msg);
   $display("%s", msg);
   $display("Errors found");
   $fatal(1, "run stopped at first error");
endtask

task automatic check_bit(input string name, input logic got, input logic want);
   if (got !== want)
   begin
      fail_now($sformatf("Error at %0t ns: %s expected %b got %b",
                         $time, name, want, got));
   end
endtask

// Write acks carry no meaningful data, header only
task automatic check_packet(input umi_pkg::umi_packet_t want);
   logic hdr_only;
   hdr_only = (want.cmd.opcode == umi_pkg::UMI_RESP_WRITE);
   if (resp.cmd !== want.cmd)
   begin
      fail_now($sformatf("Error at %0t ns: resp.cmd expected %h got %h",
                         $time, want.cmd, resp.cmd));
   end
   if (resp.dstaddr !== want.dstaddr)
   begin
      fail_now($sformatf("Error at %0t ns: resp.dstaddr expected %h got %h",
                         $time, want.dstaddr, resp.dstaddr));
   end
   if (resp.srcaddr !== want.srcaddr)
   begin
      fail_now($sformatf("Error at %0t ns: resp.srcaddr expected %h got %h",
                         $time, want.srcaddr, resp.srcaddr));
   end
   if (!hdr_only && resp.data !== want.data)
   begin
      fail_now($sformatf("Error at %0t ns: resp.data expected %h got %h",
                         $time, want.data, resp.data));
   end
endtask

//####################
// Waits, sampled 1 ns after the falling edge
//####################
task automatic wait_req_ready();
   int cycles;
   cycles = 0;
   while (!req_ready)
   begin
      if (cycles == TIMEOUT)
      begin
         fail_now("Timeout while waiting for req_ready to go high");
      end
      @(negedge clk);
      #1;
      cycles++;
   end
endtask

task automatic wait_resp_valid();
   int cycles;
   cycles = 0;
   while (!resp_valid)
   begin
      if (cycles == TIMEOUT)
      begin
         fail_now("Timeout while waiting for a response on resp_valid");
      end
      @(negedge clk);
      #1;
      cycles++;
   end
endtask

// Host holds off, response must stay put and block new requests
task automatic hold_response(input umi_pkg::umi_packet_t want, input int holdoff);
   for (int k = 0; k < holdoff; k++)
   begin
      check_bit("req_ready", req_ready, 1'b0);
      @(negedge clk);
      if (k == holdoff - 1)
      begin
         resp_ready = 1'b1;                        // Release on the last cycle
      end
      #1;
      check_bit("resp_valid", resp_valid, 1'b1);
      check_packet(want);
   end
endtask

task automatic expect_no_resp();
   repeat (QUIET_CYCLES)
   begin
      check_bit("resp_valid", resp_valid, 1'b0);
      @(negedge clk);
      #1;
   end
endtask

`endif

/* testbench/tb_umi_top.sv */
//####################
// Testbench for the UMI device top level. Applies a table of
// requests, models the memory and checks every response
//####################

`timescale 1ns/1ns

module tb_umi_top;

   localparam int TIMEOUT      = 50;           // Cycles per wait
   localparam int QUIET_CYCLES = 5;
   localparam int NUM_ROWS     = 19;

   // One request per row
   typedef struct packed {
      logic [4:0] opcode;
      logic [5:0] word;
      logic [3:0] holdoff;                     // Cycles of resp_ready low
      logic       resp_exp;
   } row_t;

   logic                 clk;
   logic                 nreset;
   umi_pkg::umi_packet_t req;
   logic                 req_valid;
   logic                 req_ready;
   umi_pkg::umi_packet_t resp;
   logic                 resp_valid;
   logic                 resp_ready;

   integer               seed;
   umi_pkg::umi_data_t   ref_mem [umi_pkg::MEM_WORDS_DEFAULT];
   umi_pkg::umi_packet_t next_req;
   umi_pkg::umi_packet_t cur_req;
   umi_pkg::umi_packet_t exp_pkt;
   logic                 queued;               // Next request already on the port

   //####################
   // Stimulus table
   //####################
   row_t rows [NUM_ROWS] = '{
      '{umi_pkg::UMI_REQ_WRITE,    6'd3,  4'd0, 1'b1},
      '{umi_pkg::UMI_REQ_READ,     6'd3,  4'd0, 1'b1},
      '{umi_pkg::UMI_REQ_WRPOSTED, 6'd10, 4'd0, 1'b0},
      '{umi_pkg::UMI_REQ_READ,     6'd10, 4'd0, 1'b1},
      '{umi_pkg::UMI_REQ_WRITE,    6'd20, 4'd0, 1'b1},
      '{umi_pkg::UMI_RESP_READ,    6'd20, 4'd0, 1'b0},   // Response codes as requests
      '{umi_pkg::UMI_RESP_WRITE,   6'd20, 4'd0, 1'b0},
      '{5'd7,                      6'd20, 4'd0, 1'b0},
      '{5'd31,                     6'd3,  4'd0, 1'b0},
      '{umi_pkg::UMI_REQ_READ,     6'd20, 4'd0, 1'b1},   // Still the acked write
      '{umi_pkg::UMI_REQ_READ,     6'd3,  4'd4, 1'b1},
      '{umi_pkg::UMI_REQ_WRITE,    6'd40, 4'd3, 1'b1},
      '{umi_pkg::UMI_REQ_WRPOSTED, 6'd41, 4'd0, 1'b0},
      '{umi_pkg::UMI_REQ_READ,     6'd40, 4'd0, 1'b1},   // Read run
      '{umi_pkg::UMI_REQ_READ,     6'd41, 4'd0, 1'b1},
      '{umi_pkg::UMI_REQ_READ,     6'd10, 4'd0, 1'b1},
      '{umi_pkg::UMI_REQ_READ,     6'd3,  4'd0, 1'b1},
      '{umi_pkg::UMI_REQ_WRITE,    6'd63, 4'd2, 1'b1},
      '{umi_pkg::UMI_REQ_READ,     6'd63, 4'd0, 1'b1}
   };

   `include "tb_umi_checks.svh"

   umi_top u_umi_top
   (
      .clk        (clk),
      .nreset     (nreset),
      .req        (req),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .resp       (resp),
      .resp_valid (resp_valid),
      .resp_ready (resp_ready)
   );

   always #5 clk = ~clk;

   // Random header fields and data, addresses from the row
   task automatic build_request(input row_t r, input int n, output umi_pkg::umi_packet_t p);
      logic [31:0] rnd;
      rnd = $random(seed);
      p.cmd.user    = rnd[31:16];
      p.cmd.len     = rnd[10:3];
      p.cmd.size    = rnd[2:0];
      p.cmd.opcode  = r.opcode;
      p.dstaddr     = 32'h0000_1000 + {24'd0, r.word, 2'b00};
      p.srcaddr     = 32'h8000_0000 + 32'(n) * 32'h0000_0100;
      rnd = $random(seed);
      p.data        = rnd;
   endtask

   // Response rules: opcode mapped, addresses swapped, rest echoed
   function automatic umi_pkg::umi_packet_t predict_resp(input umi_pkg::umi_packet_t rq,
                                                         input logic [5:0] word);
      umi_pkg::umi_packet_t e;
      logic                 is_rd;
      is_rd        = (rq.cmd.opcode == umi_pkg::UMI_REQ_READ);
      e.cmd        = rq.cmd;
      e.cmd.opcode = is_rd ? umi_pkg::UMI_RESP_READ : umi_pkg::UMI_RESP_WRITE;
      e.dstaddr    = rq.srcaddr;
      e.srcaddr    = rq.dstaddr;
      e.data       = is_rd ? ref_mem[word] : '0;
      return e;
   endfunction

   initial
   begin
      seed       = 32'hb188_f284;
      clk        = 1'b0;
      nreset     = 1'b0;
      req        = '0;
      req_valid  = 1'b0;
      resp_ready = 1'b1;
      queued     = 1'b0;
      repeat (3) @(negedge clk);
      nreset = 1'b1;
      #1;
      check_bit("resp_valid", resp_valid, 1'b0);
      check_bit("req_ready", req_ready, 1'b1);

      //####################
      // Apply loop
      //####################
      for (int i = 0; i < NUM_ROWS; i++)
      begin
         if (!queued)
         begin
            build_request(rows[i], i, next_req);
            wait_req_ready();
            @(negedge clk);
            req       = next_req;
            req_valid = 1'b1;
            #1;
         end
         queued  = 1'b0;
         cur_req = next_req;
         wait_req_ready();
         @(posedge clk);                          // Accepted on this edge
         @(negedge clk);
         req_valid  = 1'b0;
         resp_ready = (rows[i].holdoff == 4'd0);
         if (rows[i].opcode == umi_pkg::UMI_REQ_WRITE ||
             rows[i].opcode == umi_pkg::UMI_REQ_WRPOSTED)
         begin
            ref_mem[rows[i].word] = cur_req.data;
         end
         // Read after read goes in while the first response is still up
         if (i + 1 < NUM_ROWS && rows[i].opcode == umi_pkg::UMI_REQ_READ &&
             rows[i].holdoff == 4'd0 && rows[i + 1].opcode == umi_pkg::UMI_REQ_READ)
         begin
            build_request(rows[i + 1], i + 1, next_req);
            req       = next_req;
            req_valid = 1'b1;
            queued    = 1'b1;
         end
         #1;
         if (rows[i].resp_exp)
         begin
            exp_pkt = predict_resp(cur_req, rows[i].word);
            wait_resp_valid();
            check_packet(exp_pkt);
            hold_response(exp_pkt, int'(rows[i].holdoff));
         end
         else
         begin
            expect_no_resp();
         end
      end

      $display("No errors");
      $finish;
   end

endmodule
